// ==== logic/fp_noncomp_config.svh ====
// ----------------------------------------------------------
// Width macros for the non-computational FP unit
// Operand word, exponent and mantissa fields
// Class mask and status flag widths
// ----------------------------------------------------------
`ifndef FP_NONCOMP_CONFIG_SVH
`define FP_NONCOMP_CONFIG_SVH

// Single-precision operand word
`define FP_WIDTH 32
`define FP_EXP_BITS 8
`define FP_MAN_BITS 23

// One bit per class in the classification result
`define FP_CLASS_BITS 10

// NV, DZ, OF, UF, NX
`define FP_STATUS_BITS 5

`endif

// ==== logic/fp_noncomp_pkg.sv ====
// ----------------------------------------------------------
// Shared types of the non-computational FP unit
// Operation and sub-operation encodings, flags, class mask
// Operand word views and the canonical quiet NaN
// ----------------------------------------------------------
`default_nettype none

`include "fp_noncomp_config.svh"

package fp_noncomp_pkg;

  // Top-level operation
  typedef enum logic [1:0] {
    SGNJ     = 2'd0,
    MINMAX   = 2'd1,
    CMP      = 2'd2,
    CLASSIFY = 2'd3
  } fp_op_e;

  // Sub-operation, carried on the rounding-mode encodings
  // RNE: SGNJ / MIN / LE
  // RTZ: SGNJN / MAX / LT
  // RDN: SGNJX / EQ
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010
  } fp_rm_e;

  // Exception flags, invalid first
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_status_t;

  // One-hot class of an operand
  typedef enum logic [`FP_CLASS_BITS-1:0] {
    NEGINF     = 10'h001,
    NEGNORM    = 10'h002,
    NEGSUBNORM = 10'h004,
    NEGZERO    = 10'h008,
    POSZERO    = 10'h010,
    POSSUBNORM = 10'h020,
    POSNORM    = 10'h040,
    POSINF     = 10'h080,
    SNAN       = 10'h100,
    QNAN       = 10'h200
  } fp_classmask_e;

  // Special-case decode of one operand
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // IEEE 754 single-precision fields
  typedef struct packed {
    logic                    sign;
    logic [`FP_EXP_BITS-1:0] exponent;
    logic [`FP_MAN_BITS-1:0] mantissa;
  } fp_fields_t;

  // Same operand seen as fields or as a raw word
  typedef union packed {
    fp_fields_t            fields;
    logic [`FP_WIDTH-1:0]  raw;
  } fp_word_u;

  // Canonical quiet NaN, 0x7FC00000
  localparam logic [`FP_WIDTH-1:0] FP_QNAN =
    {1'b0, {`FP_EXP_BITS{1'b1}}, 1'b1, {(`FP_MAN_BITS-1){1'b0}}};

endpackage

`default_nettype wire

// ==== logic/fp_pipe_stage.sv ====
// ----------------------------------------------------------
// Single valid/ready register stage
// Payload width set by DATA_W, synchronous flush of valid
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fp_pipe_stage #(
  parameter int unsigned DATA_W = 32
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              flush_i,
  // Upstream side
  input  logic              valid_i,
  input  logic [DATA_W-1:0] data_i,
  output logic              ready_o,
  // Downstream side
  input  logic              ready_i,
  output logic              valid_o,
  output logic [DATA_W-1:0] data_o
);

  logic              valid_q;
  logic [DATA_W-1:0] data_q;
  logic              accept;

  // Free when empty or when the held item leaves this cycle
  assign ready_o = ready_i | ~valid_q;

  // New item taken in
  assign accept = valid_i & ready_o;

  // ----------------------------------------------------------
  // Valid bit
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      // Either refill or drain to a bubble
      valid_q <= valid_i;
    end
  end

  // ----------------------------------------------------------
  // Payload register
  // ----------------------------------------------------------
  // Loads on accept only
  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // Stalled item must not change under the consumer
  a_hold_when_stalled : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i) |=> $stable(data_o)
  ) else $error("pipe stage payload changed while stalled");

endmodule

`default_nettype wire

// ==== logic/fp_classifier.sv ====
// ----------------------------------------------------------
// Operand classifier
// Special-case info for both operands, class mask of A
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "fp_noncomp_config.svh"

module fp_classifier (
  input  fp_noncomp_pkg::fp_word_u      operand_a_i,
  input  fp_noncomp_pkg::fp_word_u      operand_b_i,
  output fp_noncomp_pkg::fp_info_t      info_a_o,
  output fp_noncomp_pkg::fp_info_t      info_b_o,
  output fp_noncomp_pkg::fp_classmask_e class_mask_o
);

  import fp_noncomp_pkg::*;

  // Exponent/mantissa decode shared by both operands
  function automatic fp_info_t decode(input fp_word_u word);
    fp_info_t info;
    logic     exp_ones;
    logic     exp_zero;
    logic     man_zero;
    exp_ones = &word.fields.exponent;
    exp_zero = ~|word.fields.exponent;
    man_zero = ~|word.fields.mantissa;
    info.is_normal    = !exp_zero && !exp_ones;
    info.is_subnormal = exp_zero && !man_zero;
    info.is_zero      = exp_zero && man_zero;
    info.is_inf       = exp_ones && man_zero;
    info.is_nan       = exp_ones && !man_zero;
    // Quiet bit is the mantissa MSB
    info.is_signalling = info.is_nan && !word.fields.mantissa[`FP_MAN_BITS-1];
    return info;
  endfunction

  assign info_a_o = decode(operand_a_i);
  assign info_b_o = decode(operand_b_i);

  // ----------------------------------------------------------
  // Class of operand A
  // ----------------------------------------------------------
  // One term per class, MSB first: QNAN down to NEGINF
  always_comb begin
    class_mask_o = fp_classmask_e'({
      info_a_o.is_nan & ~info_a_o.is_signalling,
      info_a_o.is_signalling,
      info_a_o.is_inf & ~operand_a_i.fields.sign,
      info_a_o.is_normal & ~operand_a_i.fields.sign,
      info_a_o.is_subnormal & ~operand_a_i.fields.sign,
      info_a_o.is_zero & ~operand_a_i.fields.sign,
      info_a_o.is_zero & operand_a_i.fields.sign,
      info_a_o.is_subnormal & operand_a_i.fields.sign,
      info_a_o.is_normal & operand_a_i.fields.sign,
      info_a_o.is_inf & operand_a_i.fields.sign
    });
  end

  // Info decode must select exactly one class term
  always_comb begin
    a_class_onehot : assert ($onehot(class_mask_o))
      else $error("class mask not one-hot: %h", class_mask_o);
  end

endmodule

`default_nettype wire

// ==== logic/fp_order_unit.sv ====
// ----------------------------------------------------------
// Operand ordering
// Minimum/maximum and LE/LT/EQ comparisons with NV flag
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "fp_noncomp_config.svh"

module fp_order_unit (
  input  fp_noncomp_pkg::fp_word_u   operand_a_i,
  input  fp_noncomp_pkg::fp_word_u   operand_b_i,
  input  fp_noncomp_pkg::fp_info_t   info_a_i,
  input  fp_noncomp_pkg::fp_info_t   info_b_i,
  input  fp_noncomp_pkg::fp_rm_e     rm_i,
  input  logic                       op_mod_i,
  output fp_noncomp_pkg::fp_word_u   minmax_result_o,
  output fp_noncomp_pkg::fp_status_t minmax_status_o,
  output fp_noncomp_pkg::fp_word_u   cmp_result_o,
  output fp_noncomp_pkg::fp_status_t cmp_status_o
);

  import fp_noncomp_pkg::*;

  logic any_nan;
  logic any_snan;
  logic equal;
  logic a_smaller;
  logic cmp_bool;

  assign any_nan  = info_a_i.is_nan | info_b_i.is_nan;
  assign any_snan = info_a_i.is_signalling | info_b_i.is_signalling;

  // Raw equality, plus +0 == -0
  assign equal = (operand_a_i.raw == operand_b_i.raw) || (info_a_i.is_zero && info_b_i.is_zero);

  // Sign-magnitude order from an unsigned compare
  // A set sign flips the magnitude order
  assign a_smaller = (operand_a_i.raw < operand_b_i.raw) ^
                     (operand_a_i.fields.sign || operand_b_i.fields.sign);

  // ----------------------------------------------------------
  // Minimum / maximum
  // ----------------------------------------------------------
  always_comb begin
    minmax_status_o    = '0;
    // Quiet operation, only sNaN is invalid
    minmax_status_o.nv = any_snan;
    if (info_a_i.is_nan && info_b_i.is_nan) begin
      minmax_result_o.raw = FP_QNAN;
    end else if (info_a_i.is_nan) begin
      minmax_result_o = operand_b_i;
    end else if (info_b_i.is_nan) begin
      minmax_result_o = operand_a_i;
    end else if (rm_i == RTZ) begin
      // MAX
      minmax_result_o = a_smaller ? operand_b_i : operand_a_i;
    end else begin
      // MIN
      minmax_result_o = a_smaller ? operand_a_i : operand_b_i;
    end
  end

  // ----------------------------------------------------------
  // Comparisons
  // ----------------------------------------------------------
  always_comb begin
    cmp_bool     = 1'b0;
    cmp_status_o = '0;
    if (any_snan) begin
      cmp_status_o.nv = 1'b1;
    end else begin
      case (rm_i)
        RNE: begin
          // LE is signalling on any NaN
          if (any_nan) cmp_status_o.nv = 1'b1;
          else cmp_bool = (a_smaller | equal) ^ op_mod_i;
        end
        RTZ: begin
          if (any_nan) cmp_status_o.nv = 1'b1;
          else cmp_bool = (a_smaller & ~equal) ^ op_mod_i;
        end
        RDN: begin
          // EQ is quiet, NaN is never equal
          cmp_bool = (equal & ~any_nan) ^ op_mod_i;
        end
        default: cmp_bool = 1'b0;
      endcase
    end
  end

  // Boolean in bit 0 of an integer result
  assign cmp_result_o.raw = {{(`FP_WIDTH-1){1'b0}}, cmp_bool};

endmodule

`default_nettype wire

// ==== logic/fp_result_select.sv ====
// ----------------------------------------------------------
// Sign injection and per-operation result mux
// Result, status, extension bit and class flag
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module fp_result_select (
  input  logic                       in_valid_i,
  input  fp_noncomp_pkg::fp_op_e     op_i,
  input  fp_noncomp_pkg::fp_rm_e     rm_i,
  input  logic                       op_mod_i,
  input  fp_noncomp_pkg::fp_word_u   operand_a_i,
  input  fp_noncomp_pkg::fp_word_u   operand_b_i,
  input  fp_noncomp_pkg::fp_word_u   minmax_result_i,
  input  fp_noncomp_pkg::fp_status_t minmax_status_i,
  input  fp_noncomp_pkg::fp_word_u   cmp_result_i,
  input  fp_noncomp_pkg::fp_status_t cmp_status_i,
  output fp_noncomp_pkg::fp_word_u   result_o,
  output fp_noncomp_pkg::fp_status_t status_o,
  output logic                       ext_bit_o,
  output logic                       is_class_o
);

  import fp_noncomp_pkg::*;

  fp_word_u sgnj_result;
  logic     rm_legal;

  // ----------------------------------------------------------
  // Sign injection
  // ----------------------------------------------------------
  // Magnitude always from A
  always_comb begin
    sgnj_result = operand_a_i;
    case (rm_i)
      RNE: sgnj_result.fields.sign = operand_b_i.fields.sign;
      RTZ: sgnj_result.fields.sign = ~operand_b_i.fields.sign;
      RDN: sgnj_result.fields.sign = operand_a_i.fields.sign ^ operand_b_i.fields.sign;
      default: sgnj_result = operand_a_i;
    endcase
  end

  // ----------------------------------------------------------
  // Result mux
  // ----------------------------------------------------------
  always_comb begin
    result_o  = '0;
    status_o  = '0;
    ext_bit_o = 1'b0;
    case (op_i)
      SGNJ: begin
        result_o  = sgnj_result;
        // op_mod asks for integer sign extension
        ext_bit_o = op_mod_i ? sgnj_result.fields.sign : 1'b1;
      end
      MINMAX: begin
        result_o  = minmax_result_i;
        status_o  = minmax_status_i;
        ext_bit_o = 1'b1;
      end
      CMP: begin
        result_o = cmp_result_i;
        status_o = cmp_status_i;
      end
      // Class goes out on its own port, result stays zero
      default: result_o = '0;
    endcase
  end

  assign is_class_o = (op_i == CLASSIFY);

  // Sub-operations each operation defines
  always_comb begin
    case (op_i)
      SGNJ:    rm_legal = rm_i inside {RNE, RTZ, RDN};
      MINMAX:  rm_legal = rm_i inside {RNE, RTZ};
      CMP:     rm_legal = rm_i inside {RNE, RTZ, RDN};
      default: rm_legal = 1'b1;
    endcase
  end

  // Registered op and rm must agree for a valid item
  always_comb begin
    a_rm_legal : assert (!in_valid_i || rm_legal)
      else $error("illegal rm %0d for op %0d", rm_i, op_i);
  end

endmodule

`default_nettype wire

// ==== logic/fp_noncomp_top.sv ====
// ----------------------------------------------------------
// Non-computational FP unit top level
// Input stage, classifier, order unit, result mux, output stage
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "fp_noncomp_config.svh"

module fp_noncomp_top (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          flush_i,
  // Request
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  logic [`FP_WIDTH-1:0]          operand_a_i,
  input  logic [`FP_WIDTH-1:0]          operand_b_i,
  input  fp_noncomp_pkg::fp_op_e        op_i,
  input  fp_noncomp_pkg::fp_rm_e        rm_i,
  input  logic                          op_mod_i,
  // Response
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output logic [`FP_WIDTH-1:0]          result_o,
  output fp_noncomp_pkg::fp_status_t    status_o,
  output logic                          ext_bit_o,
  output fp_noncomp_pkg::fp_classmask_e class_mask_o,
  output logic                          is_class_o,
  output logic                          busy_o
);

  import fp_noncomp_pkg::*;

  localparam int unsigned OP_W  = $bits(fp_op_e);
  localparam int unsigned RM_W  = $bits(fp_rm_e);
  // {op, rm, op_mod, A, B}
  localparam int unsigned IN_W  = OP_W + RM_W + 1 + 2 * `FP_WIDTH;
  // {result, status, ext_bit, class_mask, is_class}
  localparam int unsigned OUT_W = `FP_WIDTH + `FP_STATUS_BITS + 1 + `FP_CLASS_BITS + 1;

  logic             in_stage_valid;
  logic             out_stage_ready;
  logic [IN_W-1:0]  in_data_q;
  logic [OUT_W-1:0] out_data_d;
  logic [OUT_W-1:0] out_data_q;

  // Registered request fields
  fp_op_e   op_q;
  fp_rm_e   rm_q;
  logic     op_mod_q;
  fp_word_u operand_a_q;
  fp_word_u operand_b_q;

  // Datapath wires
  fp_info_t      info_a;
  fp_info_t      info_b;
  fp_classmask_e class_mask_d;
  fp_word_u      minmax_result;
  fp_status_t    minmax_status;
  fp_word_u      cmp_result;
  fp_status_t    cmp_status;
  fp_word_u      result_d;
  fp_status_t    status_d;
  logic          ext_bit_d;
  logic          is_class_d;

  // ----------------------------------------------------------
  // Input stage
  // ----------------------------------------------------------
  fp_pipe_stage #(.DATA_W(IN_W)) i_in_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .data_i  ({op_i, rm_i, op_mod_i, operand_a_i, operand_b_i}),
    .ready_o (in_ready_o),
    .ready_i (out_stage_ready),
    .valid_o (in_stage_valid),
    .data_o  (in_data_q)
  );

  assign op_q        = fp_op_e'(in_data_q[IN_W-1 -: OP_W]);
  assign rm_q        = fp_rm_e'(in_data_q[IN_W-OP_W-1 -: RM_W]);
  assign op_mod_q    = in_data_q[2*`FP_WIDTH];
  assign operand_a_q = in_data_q[2*`FP_WIDTH-1 -: `FP_WIDTH];
  assign operand_b_q = in_data_q[`FP_WIDTH-1:0];

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------
  fp_classifier i_classifier (
    .operand_a_i  (operand_a_q),
    .operand_b_i  (operand_b_q),
    .info_a_o     (info_a),
    .info_b_o     (info_b),
    .class_mask_o (class_mask_d)
  );

  fp_order_unit i_order_unit (
    .operand_a_i     (operand_a_q),
    .operand_b_i     (operand_b_q),
    .info_a_i        (info_a),
    .info_b_i        (info_b),
    .rm_i            (rm_q),
    .op_mod_i        (op_mod_q),
    .minmax_result_o (minmax_result),
    .minmax_status_o (minmax_status),
    .cmp_result_o    (cmp_result),
    .cmp_status_o    (cmp_status)
  );

  fp_result_select i_result_select (
    .in_valid_i      (in_stage_valid),
    .op_i            (op_q),
    .rm_i            (rm_q),
    .op_mod_i        (op_mod_q),
    .operand_a_i     (operand_a_q),
    .operand_b_i     (operand_b_q),
    .minmax_result_i (minmax_result),
    .minmax_status_i (minmax_status),
    .cmp_result_i    (cmp_result),
    .cmp_status_i    (cmp_status),
    .result_o        (result_d),
    .status_o        (status_d),
    .ext_bit_o       (ext_bit_d),
    .is_class_o      (is_class_d)
  );

  assign out_data_d = {result_d, status_d, ext_bit_d, class_mask_d, is_class_d};

  // ----------------------------------------------------------
  // Output stage
  // ----------------------------------------------------------
  fp_pipe_stage #(.DATA_W(OUT_W)) i_out_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_stage_valid),
    .data_i  (out_data_d),
    .ready_o (out_stage_ready),
    .ready_i (out_ready_i),
    .valid_o (out_valid_o),
    .data_o  (out_data_q)
  );

  assign result_o     = out_data_q[OUT_W-1 -: `FP_WIDTH];
  assign status_o     = out_data_q[`FP_STATUS_BITS+`FP_CLASS_BITS+1 -: `FP_STATUS_BITS];
  assign ext_bit_o    = out_data_q[`FP_CLASS_BITS+1];
  assign class_mask_o = fp_classmask_e'(out_data_q[`FP_CLASS_BITS:1]);
  assign is_class_o   = out_data_q[0];

  // Anything held in either stage
  assign busy_o = in_stage_valid | out_valid_o;

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// ----------------------------------------------------------
// Testbench clock and reset
// 40 ns clock, active-low reset held for 2 cycles
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD       = 40,
  parameter int unsigned RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/tb_fp_noncomp.sv ====
// ----------------------------------------------------------
// Testbench top of the non-computational FP unit
// Vector reader, driver with random back-pressure
// In-order scoreboard, latency, reset and flush checks
// ----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_fp_noncomp;

  import fp_noncomp_pkg::*;

  localparam int MAX_VEC = 64;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic        flush_i;
  logic        in_valid_i;
  logic [31:0] operand_a_i;
  logic [31:0] operand_b_i;
  fp_op_e      op_i;
  fp_rm_e      rm_i;
  logic        op_mod_i;
  logic        out_ready_i;

  // DUT outputs
  logic          in_ready_o;
  logic          out_valid_o;
  logic [31:0]   result_o;
  fp_status_t    status_o;
  logic          ext_bit_o;
  fp_classmask_e class_mask_o;
  logic          is_class_o;
  logic          busy_o;

  // Vector table
  string       names [MAX_VEC];
  logic [1:0]  v_op  [MAX_VEC];
  logic [2:0]  v_rm  [MAX_VEC];
  logic        v_mod [MAX_VEC];
  logic [31:0] v_a   [MAX_VEC];
  logic [31:0] v_b   [MAX_VEC];
  logic [31:0] v_res [MAX_VEC];
  logic [4:0]  v_st  [MAX_VEC];
  logic        v_ext [MAX_VEC];
  logic [9:0]  v_cls [MAX_VEC];
  int          num_vec;

  // Scoreboard of vector indices and their accept cycles
  int sb_idx [$];
  int sb_cycle [$];

  int errors = 0;
  int test_errs = 0;
  int checked = 0;
  int cycle_count = 0;
  int timeout_limit = 1000;

  tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(2)) i_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fp_noncomp_top i_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .flush_i      (flush_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .op_i         (op_i),
    .rm_i         (rm_i),
    .op_mod_i     (op_mod_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .result_o     (result_o),
    .status_o     (status_o),
    .ext_bit_o    (ext_bit_o),
    .class_mask_o (class_mask_o),
    .is_class_o   (is_class_o),
    .busy_o       (busy_o)
  );

  // ----------------------------------------------------------
  // Cycle counter and timeout
  // ----------------------------------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  // Skips blank lines and lines opening with #
  task automatic read_vectors();
    int          fd;
    int          code;
    int          n;
    string       line;
    string       nm;
    logic [1:0]  t_op;
    logic [2:0]  t_rm;
    logic        t_mod;
    logic [31:0] t_a;
    logic [31:0] t_b;
    logic [31:0] t_res;
    logic [4:0]  t_st;
    logic        t_ext;
    logic [9:0]  t_cls;
    num_vec = 0;
    fd = $fopen("tb/fp_noncomp_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file");
      $display("TB FAILED");
      $finish;
    end else begin
      while (!$feof(fd) && num_vec < MAX_VEC) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != 8'h23) begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", nm, t_op, t_rm, t_mod,
                      t_a, t_b, t_res, t_st, t_ext, t_cls);
          if (n == 10) begin
            names[num_vec] = nm;
            v_op[num_vec]  = t_op;
            v_rm[num_vec]  = t_rm;
            v_mod[num_vec] = t_mod;
            v_a[num_vec]   = t_a;
            v_b[num_vec]   = t_b;
            v_res[num_vec] = t_res;
            v_st[num_vec]  = t_st;
            v_ext[num_vec] = t_ext;
            v_cls[num_vec] = t_cls;
            num_vec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_idle();
    in_valid_i  = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = SGNJ;
    rm_i        = RNE;
    op_mod_i    = 1'b0;
  endtask

  task automatic apply_vector(input int i);
    in_valid_i  = 1'b1;
    operand_a_i = v_a[i];
    operand_b_i = v_b[i];
    op_i        = fp_op_e'(v_op[i]);
    rm_i        = fp_rm_e'(v_rm[i]);
    op_mod_i    = v_mod[i];
  endtask

  task automatic compare_field(input string tname, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("ERR %s %s expected %h actual %h", tname, field, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  // Checks the item that leaves at the coming edge
  task automatic check_output(input bit check_lat);
    int idx;
    int stamp;
    if (out_valid_o && out_ready_i) begin
      assert (sb_idx.size() > 0) else begin
        $display("an output item appeared with nothing pending");
        errors++;
        test_errs++;
      end
      if (sb_idx.size() > 0) begin
        idx   = sb_idx.pop_front();
        stamp = sb_cycle.pop_front();
        checked++;
        compare_field(names[idx], "result", v_res[idx], result_o);
        compare_field(names[idx], "status", 32'(v_st[idx]), 32'(status_o));
        compare_field(names[idx], "ext_bit", 32'(v_ext[idx]), 32'(ext_bit_o));
        compare_field(names[idx], "class", 32'(v_cls[idx]), 32'(class_mask_o));
        compare_field(names[idx], "is_class", 32'(v_op[idx] == 2'd3), 32'(is_class_o));
        if (check_lat) begin
          compare_field(names[idx], "latency", 32'd2, 32'(cycle_count - stamp));
        end else if (idx == num_vec - 1 || names[idx + 1] != names[idx]) begin
          $display("test %s finished with %0d errors", names[idx], test_errs);
          test_errs = 0;
        end
      end
    end
  endtask

  // Sends vectors first..last and drains the scoreboard
  task automatic run_vectors(input int first, input int last, input bit random_bp,
                             input bit check_lat);
    int next;
    next = first;
    while (next <= last || sb_idx.size() > 0) begin
      @(negedge clk);
      out_ready_i = random_bp ? ($urandom % 3 != 0) : 1'b1;
      if (next <= last) apply_vector(next);
      else drive_idle();
      #1;
      check_output(check_lat);
      // Output always ready, so every item goes in on its first cycle
      if (check_lat && next <= last) begin
        assert (in_ready_o) else begin
          $display("input stalled while the output was always ready");
          errors++;
          test_errs++;
        end
      end
      if (in_valid_i && in_ready_o) begin
        sb_idx.push_back(next);
        sb_cycle.push_back(cycle_count);
        next++;
      end
    end
  endtask

  task automatic check_flush();
    test_errs = 0;
    @(negedge clk);
    out_ready_i = 1'b0;
    apply_vector(3);
    @(negedge clk);
    apply_vector(4);
    @(negedge clk);
    drive_idle();
    #1;
    // Both stages full and the output stalled
    assert (busy_o && out_valid_o && !in_ready_o) else begin
      $display("pipeline was not full before the flush");
      errors++;
      test_errs++;
    end
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    #1;
    assert (!out_valid_o && !busy_o) else begin
      $display("flush left an item in the pipeline");
      errors++;
      test_errs++;
    end
    $display("test flush finished with %0d errors", test_errs);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    flush_i     = 1'b0;
    out_ready_i = 1'b0;
    drive_idle();
    void'($urandom(32'hfca3c06e));
    read_vectors();
    // Four cycles per vector plus fixed slack
    timeout_limit = 4 * num_vec + 50;

    // Reset state
    @(posedge rst_n);
    @(negedge clk);
    #1;
    assert (!out_valid_o && !busy_o && in_ready_o) else begin
      $display("wrong handshake state after reset");
      errors++;
    end
    $display("test reset finished");

    // Back-to-back items with the output always ready
    test_errs = 0;
    run_vectors(0, 2, 1'b0, 1'b1);
    $display("test latency finished with %0d errors", test_errs);

    check_flush();

    // Whole table under random back-pressure
    test_errs = 0;
    run_vectors(0, num_vec - 1, 1'b1, 1'b0);

    // Nothing may follow the last vector
    @(negedge clk);
    out_ready_i = 1'b1;
    #1;
    assert (!out_valid_o && !busy_o) else begin
      $display("an extra item was left in the pipeline after the last vector");
      errors++;
    end

    $display("%0d items checked, %0d errors", checked, errors);
    if (errors == 0 && num_vec > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/fp_noncomp_pkg.sv
logic/fp_pipe_stage.sv
logic/fp_classifier.sv
logic/fp_order_unit.sv
logic/fp_result_select.sv
logic/fp_noncomp_top.sv
tb/tb_clock_gen.sv
tb/tb_fp_noncomp.sv

// ==== Makefile ====
# Verilator build and run of the non-computational FP unit testbench

VERILATOR ?= verilator
TOP       ?= tb_fp_noncomp
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/fp_noncomp_input.txt ====
# name op rm op_mod a b result status ext_bit class_mask (all hex)
# op 0 SGNJ 1 MINMAX 2 CMP 3 CLASSIFY, rm 0 RNE 1 RTZ 2 RDN, status nv is 10
sgnj 0 0 0 3F800000 BF800000 BF800000 00 1 040
sgnj 0 1 0 3F800000 BF800000 3F800000 00 1 040
sgnj 0 2 1 C0000000 BF800000 40000000 00 0 002
sgnj 0 0 1 7FC00000 80000000 FFC00000 00 1 200
sgnj 0 2 0 7F800001 3F800000 7F800001 00 1 100
minmax 1 0 0 3F800000 40000000 3F800000 00 1 040
minmax 1 1 0 3F800000 40000000 40000000 00 1 040
minmax 1 0 0 C0000000 3F800000 C0000000 00 1 002
minmax 1 1 0 C0400000 C0000000 C0000000 00 1 002
minmax 1 0 0 80000000 00000001 80000000 00 1 008
minmax 1 0 0 7FC00000 3F800000 3F800000 00 1 200
minmax 1 1 0 40000000 7FC00000 40000000 00 1 040
minmax 1 0 0 7FC00000 FFC00000 7FC00000 00 1 200
minmax 1 1 0 7F800001 3F800000 3F800000 10 1 100
cmp 2 0 0 3F800000 40000000 00000001 00 0 040
cmp 2 0 1 3F800000 40000000 00000000 00 0 040
cmp 2 1 0 40000000 40000000 00000000 00 0 040
cmp 2 1 1 40000000 40000000 00000001 00 0 040
cmp 2 2 0 00000000 80000000 00000001 00 0 010
cmp 2 2 1 3F800000 40000000 00000001 00 0 040
cmp 2 1 0 C0000000 3F800000 00000001 00 0 002
cmp 2 0 0 7FC00000 3F800000 00000000 10 0 200
cmp 2 2 0 7FC00000 7FC00000 00000000 00 0 200
cmp 2 2 0 3F800000 7F800001 00000000 10 0 040
cmp 2 1 0 7F800001 3F800000 00000000 10 0 100
classify 3 0 0 FF800000 00000000 00000000 00 0 001
classify 3 0 0 BF800000 00000000 00000000 00 0 002
classify 3 0 0 80000001 00000000 00000000 00 0 004
classify 3 0 0 80000000 00000000 00000000 00 0 008
classify 3 0 0 00000000 00000000 00000000 00 0 010
classify 3 0 0 00000001 00000000 00000000 00 0 020
classify 3 0 0 3F800000 00000000 00000000 00 0 040
classify 3 0 0 7F800000 00000000 00000000 00 0 080
classify 3 0 0 7F800001 00000000 00000000 00 0 100
classify 3 0 0 7FC00000 00000000 00000000 00 0 200
